// File: rob_pkg.sv
`default_nettype none

package rob_pkg;

	// Physical register file
	localparam int num_phys_regs = 64;
	localparam int tag_bits = $clog2(num_phys_regs);

	// Tags 0 to 31 sit in the architectural map after reset
	localparam int first_free_tag = 32;

	// Free list sizing
	localparam int free_depth = num_phys_regs - first_free_tag;
	localparam int free_cnt_bits = $clog2(free_depth + 1); // Holds 0 to free_depth

	typedef logic [tag_bits-1:0] phys_tag_t;

	// One reorder buffer row, 15 bits
	typedef struct packed {
		phys_tag_t t_new; // Destination tag from the free list
		phys_tag_t t_old; // Previous mapping, freed at retire
		logic      halt;
		logic      ready; // Set by a CDB match
		logic      busy;
	} rob_row_t;

endpackage

`default_nettype wire

// File: retire_if.sv
`timescale 1ns/1ps
`default_nettype none

// Retired rows, lane 0 oldest, lanes contiguous from 0
interface retire_if #(
	parameter int ways = 2
);
	import rob_pkg::*;

	logic      [ways-1:0] valid;
	phys_tag_t [ways-1:0] t_old;
	phys_tag_t [ways-1:0] t_new;
	logic      [ways-1:0] halt;

	modport rob_side (
		output valid, t_old, t_new, halt
	);

	// Free list only recycles the old tags
	modport list_side (
		input valid, t_old
	);

endinterface

`default_nettype wire

// File: tag_cam.sv
`timescale 1ns/1ps
`default_nettype none

module tag_cam #(
	parameter int ways = 2,
	parameter int rows = 8
) (
	input  rob_pkg::phys_tag_t [rows-1:0] row_tags,
	input  logic               [ways-1:0] cdb_valid,
	input  rob_pkg::phys_tag_t [ways-1:0] cdb_tag,
	output logic               [rows-1:0] hits
);

	logic [rows-1:0][ways-1:0] match; // Row by CDB lane

	always_comb begin
		for (int r = 0; r < rows; r++) begin
			for (int w = 0; w < ways; w++) begin
				match[r][w] = cdb_valid[w] && (cdb_tag[w] == row_tags[r]);
			end
		end
	end

	// Any lane hitting the row
	always_comb begin
		for (int r = 0; r < rows; r++) begin
			hits[r] = |match[r];
		end
	end

endmodule

`default_nettype wire

// File: free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list #(
	parameter int ways = 2
) (
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               flush,
	output rob_pkg::phys_tag_t [ways-1:0]      free_tags,
	output logic [rob_pkg::free_cnt_bits-1:0]  free_count,
	input  logic [$clog2(ways+1)-1:0]          take_count,
	retire_if.list_side                        retired
);
	import rob_pkg::*;

	localparam int ptr_bits = $clog2(free_depth);
	localparam int cnt_bits = $clog2(ways + 1);

	phys_tag_t [free_depth-1:0] slots;
	logic [ptr_bits-1:0]        head;
	logic [ptr_bits-1:0]        tail;
	logic [free_cnt_bits-1:0]   count;
	logic [cnt_bits-1:0]        ret_count;

	// Next tags at the head, only the first free_count are meaningful
	always_comb begin
		for (int i = 0; i < ways; i++) begin
			free_tags[i] = slots[head + ptr_bits'(i)];
		end
	end

	assign free_count = count;
	assign ret_count = cnt_bits'($countones(retired.valid)); // Lanes are contiguous

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			for (int i = 0; i < free_depth; i++) begin
				slots[i] <= phys_tag_t'(first_free_tag + i);
			end
			head <= '0;
			tail <= '0; // Full queue, tail wraps onto head
			count <= free_cnt_bits'(free_depth);
		end else begin
			for (int i = 0; i < ways; i++) begin
				if (retired.valid[i]) begin
					slots[tail + ptr_bits'(i)] <= retired.t_old[i];
				end
			end
			head <= head + ptr_bits'(take_count);
			tail <= tail + ptr_bits'(ret_count);
			count <= count - free_cnt_bits'(take_count) + free_cnt_bits'(ret_count);
		end
	end

	// Grants from the ROB never outrun the queue
	a_no_underflow: assert property (@(posedge clock) disable iff (reset || flush)
		int'(take_count) <= int'(count));

	// Returns never exceed the tags handed out since the last reload
	a_no_overflow: assert property (@(posedge clock) disable iff (reset || flush)
		int'(count) - int'(take_count) + int'(ret_count) <= free_depth);

endmodule

`default_nettype wire

// File: rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob #(
	parameter int ways = 2,
	parameter int rob_depth = 8
) (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              flush,
	input  logic [ways-1:0]                   dispatch_valid,
	input  rob_pkg::phys_tag_t [ways-1:0]     old_tag,
	input  logic [ways-1:0]                   halt,
	output logic [ways-1:0]                   dispatch_grant,
	input  rob_pkg::phys_tag_t [ways-1:0]     free_tags,
	input  logic [rob_pkg::free_cnt_bits-1:0] free_count,
	output logic [$clog2(ways+1)-1:0]         take_count,
	input  logic [ways-1:0]                   cdb_valid,
	input  rob_pkg::phys_tag_t [ways-1:0]     cdb_tag,
	retire_if.rob_side                        retired,
	output logic [$clog2(rob_depth+1)-1:0]    free_rows
);
	import rob_pkg::*;

	localparam int ptr_bits = $clog2(rob_depth);
	localparam int cnt_bits = $clog2(ways + 1);
	localparam int row_cnt_bits = $clog2(rob_depth + 1);

	rob_row_t [rob_depth-1:0] rows_q;
	rob_row_t [rob_depth-1:0] rows_next;
	logic [ptr_bits-1:0]      head;
	logic [ptr_bits-1:0]      tail;
	logic [row_cnt_bits-1:0]  used; // Busy rows
	logic [row_cnt_bits-1:0]  used_next;
	logic [row_cnt_bits-1:0]  rows_avail;

	phys_tag_t [rob_depth-1:0] row_tags;
	logic [rob_depth-1:0]      hits;
	logic [rob_depth-1:0]      ready_now;
	logic [rob_depth-1:0]      row_retiring;

	logic [ways-1:0][ptr_bits-1:0] retire_idx;
	logic [ways-1:0][ptr_bits-1:0] dispatch_idx;
	logic [ways-1:0]               retire_go;
	logic [cnt_bits-1:0]           n_retire;
	logic [ways-1:0]               clobber;

	always_comb begin
		for (int r = 0; r < rob_depth; r++) begin
			row_tags[r] = rows_q[r].t_new;
		end
	end

	tag_cam #(
		.ways (ways),
		.rows (rob_depth)
	) cam (
		.row_tags  (row_tags),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.hits      (hits)
	);

	// A CDB hit counts as ready in the same cycle
	always_comb begin
		for (int r = 0; r < rob_depth; r++) begin
			ready_now[r] = rows_q[r].busy && (rows_q[r].ready || hits[r]);
		end
	end

	// Longest ready prefix from the head
	always_comb begin
		logic chain;
		chain = !flush;
		row_retiring = '0;
		for (int i = 0; i < ways; i++) begin
			retire_idx[i] = head + ptr_bits'(i);
			chain = chain && ready_now[retire_idx[i]];
			retire_go[i] = chain;
			if (chain) begin
				row_retiring[retire_idx[i]] = 1'b1;
			end
		end
		n_retire = cnt_bits'($countones(retire_go));
	end

	always_comb begin
		for (int i = 0; i < ways; i++) begin
			retired.valid[i] = retire_go[i];
			retired.t_old[i] = rows_q[retire_idx[i]].t_old;
			retired.t_new[i] = rows_q[retire_idx[i]].t_new;
			retired.halt[i] = rows_q[retire_idx[i]].halt;
		end
	end

	// Rows freed by this cycle's retire are usable now
	assign rows_avail = row_cnt_bits'(rob_depth) - used + row_cnt_bits'(n_retire);

	// A lane is granted only with every lower lane granted
	always_comb begin
		logic chain;
		chain = !flush;
		for (int i = 0; i < ways; i++) begin
			dispatch_idx[i] = tail + ptr_bits'(i);
			chain = chain && dispatch_valid[i]
				&& (i < int'(rows_avail)) && (i < int'(free_count));
			dispatch_grant[i] = chain;
			clobber[i] = chain && rows_q[dispatch_idx[i]].busy
				&& !row_retiring[dispatch_idx[i]];
		end
		take_count = cnt_bits'($countones(dispatch_grant));
	end

	always_comb begin
		rows_next = rows_q;
		for (int r = 0; r < rob_depth; r++) begin
			rows_next[r].ready = rows_q[r].ready || (rows_q[r].busy && hits[r]);
			if (row_retiring[r]) begin
				rows_next[r].busy = 1'b0;
			end
		end
		for (int i = 0; i < ways; i++) begin
			if (dispatch_grant[i]) begin
				rows_next[dispatch_idx[i]].t_new = free_tags[i];
				rows_next[dispatch_idx[i]].t_old = old_tag[i];
				rows_next[dispatch_idx[i]].halt = halt[i];
				rows_next[dispatch_idx[i]].ready = 1'b0;
				rows_next[dispatch_idx[i]].busy = 1'b1;
			end
		end
	end

	assign used_next = used - row_cnt_bits'(n_retire) + row_cnt_bits'(take_count);
	assign free_rows = flush ? row_cnt_bits'(rob_depth) : row_cnt_bits'(rob_depth) - used_next;

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			rows_q <= '0;
			head <= '0;
			tail <= '0;
			used <= '0;
		end else begin
			rows_q <= rows_next;
			head <= head + ptr_bits'(n_retire);
			tail <= tail + ptr_bits'(take_count);
			used <= used_next;
		end
	end

	// Dispatch only lands on empty rows or rows leaving this cycle
	a_no_clobber: assert property (@(posedge clock) disable iff (reset)
		clobber == '0);

endmodule

`default_nettype wire

// File: rename_retire_top.sv
`timescale 1ns/1ps
`default_nettype none

module rename_retire_top #(
	parameter int ways = 2,
	parameter int rob_depth = 8
) (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           flush,
	input  logic [ways-1:0]                dispatch_valid,
	input  rob_pkg::phys_tag_t [ways-1:0]  old_tag,
	input  logic [ways-1:0]                halt,
	output logic [ways-1:0]                dispatch_grant,
	output rob_pkg::phys_tag_t [ways-1:0]  new_tag,
	input  logic [ways-1:0]                cdb_valid,
	input  rob_pkg::phys_tag_t [ways-1:0]  cdb_tag,
	output logic [ways-1:0]                retire_valid,
	output rob_pkg::phys_tag_t [ways-1:0]  retire_t_old,
	output rob_pkg::phys_tag_t [ways-1:0]  retire_t_new,
	output logic [ways-1:0]                retire_halt,
	output logic [$clog2(rob_depth+1)-1:0] free_rows
);
	import rob_pkg::*;

	logic [free_cnt_bits-1:0]  free_count;
	logic [$clog2(ways+1)-1:0] take_count;

	retire_if #(.ways(ways)) retire_bus ();

	free_list #(
		.ways (ways)
	) tags (
		.clock      (clock),
		.reset      (reset),
		.flush      (flush),
		.free_tags  (new_tag), // Head of the free list is the offered tag
		.free_count (free_count),
		.take_count (take_count),
		.retired    (retire_bus.list_side)
	);

	rob #(
		.ways      (ways),
		.rob_depth (rob_depth)
	) reorder (
		.clock          (clock),
		.reset          (reset),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.old_tag        (old_tag),
		.halt           (halt),
		.dispatch_grant (dispatch_grant),
		.free_tags      (new_tag),
		.free_count     (free_count),
		.take_count     (take_count),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.retired        (retire_bus.rob_side),
		.free_rows      (free_rows)
	);

	assign retire_valid = retire_bus.valid;
	assign retire_t_old = retire_bus.t_old;
	assign retire_t_new = retire_bus.t_new;
	assign retire_halt = retire_bus.halt;

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real period = 20.0,
	parameter int reset_cycles = 4
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(period / 2.0) clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // Released between edges
	end

endmodule

`default_nettype wire

// File: rob_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rob_checker #(
	parameter int ways = 2,
	parameter int rob_depth = 8
) (
	input logic                           clock,
	input logic                           reset,
	input logic                           flush,
	input logic [ways-1:0]                dispatch_valid,
	input rob_pkg::phys_tag_t [ways-1:0]  old_tag,
	input logic [ways-1:0]                halt,
	input logic [ways-1:0]                dispatch_grant,
	input rob_pkg::phys_tag_t [ways-1:0]  new_tag,
	input logic [ways-1:0]                cdb_valid,
	input rob_pkg::phys_tag_t [ways-1:0]  cdb_tag,
	input logic [ways-1:0]                retire_valid,
	input rob_pkg::phys_tag_t [ways-1:0]  retire_t_old,
	input rob_pkg::phys_tag_t [ways-1:0]  retire_t_new,
	input logic [ways-1:0]                retire_halt,
	input logic [$clog2(rob_depth+1)-1:0] free_rows
);
	import rob_pkg::*;

	rob_row_t  model_q[$]; // Oldest first
	phys_tag_t free_q[$];
	int        value_errors = 0;
	int        granted_total = 0;
	int        retired_total = 0;
	int        flushed_total = 0;
	int        since_reload = 0;
	int        live_rows = 0;
	logic      saw_full = 1'b0;
	logic      saw_recycle = 1'b0;

	function automatic logic cdb_hit(input phys_tag_t tag);
		logic hit;
		hit = 1'b0;
		for (int w = 0; w < ways; w++) begin
			hit = hit | (cdb_valid[w] && (cdb_tag[w] == tag));
		end
		return hit;
	endfunction

	task automatic reload_free();
		free_q.delete();
		for (int t = first_free_tag; t < num_phys_regs; t++) begin
			free_q.push_back(phys_tag_t'(t));
		end
		since_reload = 0;
	endtask

	task automatic compare_value(input string name, input int lane,
		input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("Fail %s[%0d] at %0t: expected %h, got %h",
				name, lane, $time, expected, actual);
		end
	endtask

	always @(posedge clock) begin
		rob_row_t        row;
		logic [ways-1:0] exp_retire;
		logic [ways-1:0] exp_grant;
		logic            chain;
		int              n_ret;
		int              n_grant;
		int              exp_free;
		if (reset) begin
			model_q.delete();
			reload_free();
			live_rows = 0;
		end else begin
			// Ready prefix from the oldest row including CDB hits
			chain = !flush;
			n_ret = 0;
			for (int i = 0; i < ways; i++) begin
				if (i < model_q.size()) begin
					chain = chain && (model_q[i].ready || cdb_hit(model_q[i].t_new));
				end else begin
					chain = 1'b0;
				end
				exp_retire[i] = chain;
				n_ret += int'(chain);
				compare_value("retire_valid", i, 8'(exp_retire[i]), 8'(retire_valid[i]));
				if (exp_retire[i]) begin
					compare_value("retire_t_old", i, 8'(model_q[i].t_old), 8'(retire_t_old[i]));
					compare_value("retire_t_new", i, 8'(model_q[i].t_new), 8'(retire_t_new[i]));
					compare_value("retire_halt", i, 8'(model_q[i].halt), 8'(retire_halt[i]));
				end
			end
			chain = !flush;
			n_grant = 0;
			for (int i = 0; i < ways; i++) begin
				chain = chain && dispatch_valid[i]
					&& (i < rob_depth - model_q.size() + n_ret) && (i < free_q.size());
				exp_grant[i] = chain;
				n_grant += int'(chain);
				compare_value("dispatch_grant", i, 8'(exp_grant[i]), 8'(dispatch_grant[i]));
				if (exp_grant[i]) begin
					compare_value("new_tag", i, 8'(free_q[i]), 8'(new_tag[i]));
				end
			end
			exp_free = flush ? rob_depth : rob_depth - (model_q.size() - n_ret + n_grant);
			compare_value("free_rows", 0, 8'(exp_free), 8'(free_rows));
			if (free_rows == '0) begin
				saw_full = 1'b1;
			end
			granted_total += $countones(dispatch_grant); // As seen on the DUT ports
			retired_total += $countones(retire_valid);
			if (flush) begin
				flushed_total += model_q.size();
				model_q.delete();
				reload_free();
			end else begin
				for (int i = 0; i < n_ret; i++) begin
					row = model_q.pop_front();
					free_q.push_back(row.t_old); // Recycled at the tail
				end
				foreach (model_q[r]) begin
					row = model_q[r];
					row.ready = row.ready | cdb_hit(row.t_new);
					model_q[r] = row;
				end
				for (int i = 0; i < n_grant; i++) begin
					row.t_new = free_q.pop_front();
					row.t_old = old_tag[i];
					row.halt = halt[i];
					row.ready = 1'b0;
					row.busy = 1'b1;
					model_q.push_back(row);
					since_reload++;
				end
				if (since_reload > num_phys_regs - first_free_tag) begin
					saw_recycle = 1'b1;
				end
			end
			live_rows = model_q.size();
		end
	end

endmodule

`default_nettype wire

// File: rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb;
	import rob_pkg::*;

	localparam int ways = 2;
	localparam int rob_depth = 8;
	localparam int random_rows = 64;

	typedef struct packed {
		logic       flush;
		logic [1:0] mask; // Lanes offered
		logic [1:0] halt;
		logic [7:0] done; // Bit k completes the k-th oldest open dispatch
	} step_t;

	logic                           clock;
	logic                           reset;
	logic                           flush;
	logic [ways-1:0]                dispatch_valid;
	phys_tag_t [ways-1:0]           old_tag;
	logic [ways-1:0]                halt;
	logic [ways-1:0]                dispatch_grant;
	phys_tag_t [ways-1:0]           new_tag;
	logic [ways-1:0]                cdb_valid;
	phys_tag_t [ways-1:0]           cdb_tag;
	logic [ways-1:0]                retire_valid;
	phys_tag_t [ways-1:0]           retire_t_old;
	phys_tag_t [ways-1:0]           retire_t_new;
	logic [ways-1:0]                retire_halt;
	logic [$clog2(rob_depth+1)-1:0] free_rows;

	step_t       steps[$];
	phys_tag_t   open_tags[$]; // Dispatched, not yet broadcast
	phys_tag_t   pend_tag[$];
	logic        pend_halt[$];
	logic [31:0] rng_state = 32'd29025;
	int          tb_errors = 0;

	tb_clock_gen clocks (.clock(clock), .reset(reset));

	rename_retire_top #(.ways(ways), .rob_depth(rob_depth)) UUT (.*);

	rob_checker #(.ways(ways), .rob_depth(rob_depth)) scoreboard (.*);

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic add_step(input logic f, input logic [1:0] m, input logic [1:0] h,
		input logic [7:0] d);
		steps.push_back({f, m, h, d});
	endtask

	task automatic build_table();
		logic [31:0] r;
		add_step(0, 2'b00, 2'b00, 8'h00); // Idle after reset
		add_step(0, 2'b00, 2'b00, 8'h00);
		add_step(0, 2'b01, 2'b01, 8'h00);
		add_step(0, 2'b10, 2'b00, 8'h00); // Lane 1 alone, no grant
		add_step(0, 2'b11, 2'b10, 8'h00);
		add_step(0, 2'b11, 2'b00, 8'h00);
		add_step(0, 2'b11, 2'b00, 8'h00);
		add_step(0, 2'b11, 2'b00, 8'h00); // ROB full here
		add_step(0, 2'b11, 2'b01, 8'h00);
		add_step(0, 2'b11, 2'b00, 8'h06); // Younger rows complete first
		add_step(0, 2'b11, 2'b00, 8'h08);
		add_step(0, 2'b11, 2'b00, 8'h01);
		add_step(0, 2'b11, 2'b11, 8'h03);
		add_step(0, 2'b01, 2'b00, 8'h05);
		add_step(0, 2'b11, 2'b00, 8'h30);
		add_step(0, 2'b00, 2'b00, 8'hff);
		add_step(0, 2'b11, 2'b01, 8'h02);
		add_step(1, 2'b11, 2'b00, 8'h00); // Flush with rows in flight
		add_step(0, 2'b00, 2'b00, 8'h00);
		add_step(0, 2'b01, 2'b00, 8'h00);
		add_step(0, 2'b11, 2'b10, 8'h01);
		add_step(0, 2'b11, 2'b00, 8'h03);
		for (int i = 0; i < random_rows; i++) begin
			r = xorshift32();
			add_step(0, (r[2:0] == 3'd0) ? 2'b10 : (r[1] ? 2'b11 : 2'b01), r[4:3], r[15:8]);
		end
	endtask

	// Starts and ends on a falling edge
	task automatic apply_step(input step_t s);
		int next;
		int picked;
		int used_idx[$];
		while (pend_tag.size() < ways) begin
			pend_halt.push_back(s.halt[pend_tag.size()]);
			pend_tag.push_back(phys_tag_t'(xorshift32()));
		end
		next = 0;
		for (int k = 0; k < ways; k++) begin
			dispatch_valid[k] = s.mask[k];
			old_tag[k] = s.mask[k] ? pend_tag[next] : '0;
			halt[k] = s.mask[k] ? pend_halt[next] : 1'b0;
			next += int'(s.mask[k]);
		end
		picked = 0;
		cdb_valid = '0;
		cdb_tag = '0;
		for (int k = 0; k < 8; k++) begin
			if (!s.flush && s.done[k] && (k < open_tags.size()) && (picked < ways)) begin
				cdb_valid[picked] = 1'b1;
				cdb_tag[picked] = open_tags[k];
				used_idx.push_front(k); // Highest index deleted first
				picked++;
			end
		end
		foreach (used_idx[j]) begin
			open_tags.delete(used_idx[j]);
		end
		flush = s.flush;
		@(posedge clock);
		for (int k = 0; k < ways; k++) begin
			if (dispatch_grant[k]) begin
				open_tags.push_back(new_tag[k]);
				void'(pend_tag.pop_front());
				void'(pend_halt.pop_front());
			end
		end
		if (s.flush) begin
			open_tags.delete();
		end
		@(negedge clock);
	endtask

	task automatic run_watchdog(input int cycles);
		repeat (cycles) @(posedge clock);
		$display("Timeout: no end of test after %0d cycles", cycles);
		$display("Checks failed");
		$finish;
	endtask

	initial begin
		flush = 1'b0;
		dispatch_valid = '0;
		old_tag = '0;
		halt = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		build_table();
		fork
			run_watchdog(40 * steps.size() + 200);
		join_none
		@(negedge reset);
		foreach (steps[i]) begin
			apply_step(steps[i]);
		end
		do begin
			apply_step({1'b0, 2'b00, 2'b00, 8'hff}); // Complete everything still open
		end while (open_tags.size() > 0 || int'(free_rows) != rob_depth);
		repeat (2) apply_step('0);
		if (scoreboard.granted_total != scoreboard.retired_total + scoreboard.flushed_total
			|| scoreboard.live_rows != 0) begin
			tb_errors++;
			$display("Entries lost or duplicated: %0d granted, %0d retired, %0d flushed",
				scoreboard.granted_total, scoreboard.retired_total, scoreboard.flushed_total);
		end
		if (!scoreboard.saw_full) begin
			tb_errors++;
			$display("The reorder buffer never filled up");
		end
		if (!scoreboard.saw_recycle) begin
			tb_errors++;
			$display("No recycled tag was handed out again");
		end
		$display("Errors: %0d value, %0d other", scoreboard.value_errors, tb_errors);
		if (scoreboard.value_errors == 0 && tb_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rob_pkg.sv
retire_if.sv
tag_cam.sv
free_list.sv
rob.sv
rename_retire_top.sv
tb_clock_gen.sv
rob_checker.sv
rob_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = rob_tb
RTL_TOP    = rename_retire_top
FILELIST   = compile.f
RTL_FILES  = rob_pkg.sv retire_if.sv tag_cam.sv free_list.sv rob.sv rename_retire_top.sv
FLAGS      = --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = Checks failed
PASS_MSG   = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(TOOL) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
